// File: filelist.f
ac97_frame_pkg.sv
codec_reg_pkg.sv
codec_control.sv
pcm_sample_path.sv
ac97_link.sv
ac97_audio_top.sv
ac97_audio_chk.sv
tb_ac97_audio_top.sv

// File: tb_ac97_audio_top.sv
`timescale 1ns/10ps

module tb_ac97_audio_top import ac97_frame_pkg::*, codec_reg_pkg::*; ();

  // rx_pos value while no frame is being received
  localparam int rx_idle = 300;
  localparam int n_play  = 6;

  logic          clock_27mhz;
  logic          ac97_bit_clock;
  logic          reset;
  volume_t       volume;
  audio_sample_t audio_out_data;
  audio_sample_t audio_in_data;
  logic          ready;
  logic          audio_reset_b;
  logic          ac97_sdata_out;
  logic          ac97_sdata_in;
  logic          ac97_synch;

  integer        seed = 88225;
  int            rx_pos = rx_idle;
  int            frame_index = 0;
  int            ready_count = 0;
  int            ready_at_rise = 0;
  logic          prev_synch = 1'b0;
  logic [0:95]   rx_head;
  logic [4:0]    rx_tags;
  codec_addr_t   rx_addr;
  codec_data_t   rx_data;
  pcm_sample_t   rx_left;
  pcm_sample_t   rx_right;
  audio_sample_t cap_byte;

  // playback byte and codec input byte, one pair per row
  audio_sample_t play_tbl [0:n_play-1];
  audio_sample_t cap_tbl  [0:n_play-1];
  // expected command per sequencer state
  codec_addr_t   exp_addr [0:15];
  codec_data_t   exp_data [0:15];

  ac97_audio_top #(
    .reset_delay_cycles(31)
  ) uut (
    .clock_27mhz   (clock_27mhz),
    .reset         (reset),
    .volume        (volume),
    .audio_out_data(audio_out_data),
    .audio_in_data (audio_in_data),
    .ready         (ready),
    .audio_reset_b (audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in (ac97_sdata_in),
    .ac97_synch    (ac97_synch),
    .ac97_bit_clock(ac97_bit_clock)
  );

  initial begin
    clock_27mhz = 1'b0;
    forever #50 clock_27mhz = ~clock_27mhz;
  end

  initial begin
    ac97_bit_clock = 1'b0;
    forever #110 ac97_bit_clock = ~ac97_bit_clock;
  end

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input string name, input audio_sample_t actual,
                              input audio_sample_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input codec_addr_t actual,
                            input codec_addr_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual));
    end
  endtask

  task automatic check_data(input string name, input codec_data_t actual,
                            input codec_data_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // codec model
  ////////////////////////////////////////////////////////////

  // system-side ready strobes, compared per frame below
  always @(posedge clock_27mhz) begin
    if (ready === 1'b1) begin
      ready_count++;
    end
  end

  // bit p of a frame shows on the negedge p+1 clocks after the sync rise
  always @(negedge ac97_bit_clock) begin
    if (reset) begin
      rx_pos      = rx_idle;
      frame_index = 0;
    end else begin
      if (rx_pos < frame_bits) begin
        if (rx_pos <= slot_right_last) begin
          rx_head[rx_pos] = ac97_sdata_out;
        end
        rx_pos++;
        if (rx_pos == frame_bits) begin
          rx_tags  = rx_head[0 +: 5];
          rx_addr  = rx_head[slot_cmd_addr_first +: 8];
          rx_data  = rx_head[slot_cmd_data_first +: 16];
          rx_left  = rx_head[slot_left_first +: 20];
          rx_right = rx_head[slot_right_first +: 20];
          frame_index++;
        end
      end
      if (ac97_synch === 1'b1 && prev_synch === 1'b0) begin
        if (rx_pos != rx_idle && rx_pos != frame_bits) begin
          fail_run($sformatf("ac97_synch rose %0d bit clocks into a frame", rx_pos));
        end
        if (rx_pos == frame_bits && ready_count - ready_at_rise != 1) begin
          fail_run($sformatf("%0d ready pulses in one frame", ready_count - ready_at_rise));
        end
        ready_at_rise = ready_count;
        rx_pos        = 0;
      end else if (rx_pos == frame_bits) begin
        fail_run("ac97_synch did not rise after 256 bit clocks");
      end
    end
    prev_synch = ac97_synch;
  end

  // slot 3 input, msb lined up with the controller's slot 3 msb
  always @(posedge ac97_bit_clock) begin
    #1;
    if (rx_pos >= slot_left_first && rx_pos < slot_left_first + audio_bits) begin
      ac97_sdata_in = cap_byte[audio_bits - 1 - (rx_pos - slot_left_first)];
    end else begin
      ac97_sdata_in = 1'b0;
    end
  end

  // any failed assertion ends the run
  always @(posedge clock_27mhz) begin
    if (uut.u_chk.assert_failures != 0) begin
      fail_run("a concurrent assertion in ac97_audio_chk failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // waits and test steps
  ////////////////////////////////////////////////////////////

  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(posedge clock_27mhz);
      #1;
      n++;
      if (n > 1000) fail_run("timed out waiting for ready");
    end while (ready !== 1'b1);
  endtask

  task automatic wait_frame(input int target);
    int n;
    n = 0;
    while (frame_index < target) begin
      @(posedge clock_27mhz);
      #1;
      n++;
      if (n > 2000) fail_run($sformatf("timed out waiting for decoded frame %0d", target));
    end
  endtask

  // system-domain outputs follow reset on the next clock
  task automatic check_system_idle();
    check_bit("ready", ready, 1'b0);
    check_bit("audio_reset_b", audio_reset_b, 1'b0);
  endtask

  // link outputs clear a few bit clocks later, after the two-flop reset crossing
  task automatic check_idle_outputs();
    check_system_idle();
    check_bit("ac97_synch", ac97_synch, 1'b0);
    check_bit("ac97_sdata_out", ac97_sdata_out, 1'b0);
  endtask

  // 5 cycles of reset, then time the codec release
  task automatic apply_reset();
    int n;
    reset = 1'b1;
    repeat (5) @(posedge clock_27mhz);
    #1;
    check_system_idle();
    reset = 1'b0;
    @(posedge clock_27mhz);
    #1;
    check_idle_outputs();
    n = 1;
    while (audio_reset_b !== 1'b1) begin
      @(posedge clock_27mhz);
      #1;
      n++;
      if (n > 40) fail_run("audio_reset_b was never released");
    end
    if (n < 32 || n > 33) begin
      fail_run($sformatf("audio_reset_b released after %0d cycles, not 32 or 33", n));
    end
  endtask

  // read-id everywhere except the listed register writes
  task automatic build_cmd_table(input volume_t vol);
    int atten;
    atten = 31 - vol;
    for (int s = 0; s < 16; s++) begin
      exp_addr[s] = reg_read_id;
      exp_data[s] = '0;
    end
    // same 5-bit field in the left and the right byte
    exp_addr[3]  = reg_headphone_vol;
    exp_data[3]  = codec_data_t'(atten * 'h0101);
    exp_addr[5]  = reg_pcm_vol;
    exp_data[5]  = pcm_vol_value;
    exp_addr[6]  = reg_rec_select;
    exp_data[6]  = codec_data_t'(rec_source_mic * 'h0101);
    exp_addr[7]  = reg_rec_gain;
    exp_data[7]  = rec_gain_value;
    exp_addr[9]  = reg_mic_gain;
    exp_data[9]  = mic_gain_value;
    exp_addr[10] = reg_beep_vol;
    exp_data[10] = beep_vol_value;
    exp_addr[11] = reg_general;
    exp_data[11] = general_value;
  endtask

  // frame k after reset carries the command of state k
  task automatic run_commands(input volume_t vol);
    volume = vol;
    build_cmd_table(vol);
    apply_reset();
    wait_frame(1);
    check_bit("slot 0 frame valid", rx_tags[4], 1'b1);
    check_bit("slot 0 address valid", rx_tags[3], 1'b0);
    check_bit("slot 0 data valid", rx_tags[2], 1'b0);
    check_bit("slot 0 left valid", rx_tags[1], 1'b0);
    check_bit("slot 0 right valid", rx_tags[0], 1'b0);
    for (int k = 1; k <= 16; k++) begin
      wait_frame(k + 1);
      check_bit("slot 0 address valid", rx_tags[3], 1'b1);
      check_bit("slot 0 data valid", rx_tags[2], 1'b1);
      check_addr("slot 1 address", rx_addr, exp_addr[k % 16]);
      check_data("slot 2 data", rx_data, exp_data[k % 16]);
    end
  endtask

  task automatic run_samples();
    int base;
    for (int i = 0; i < n_play; i++) begin
      wait_ready();
      base           = frame_index;
      audio_out_data = play_tbl[i];
      cap_byte       = cap_tbl[i];
      // capture shows one cycle after the next frame's ready
      wait_ready();
      @(posedge clock_27mhz);
      #1;
      check_sample("audio_in_data", audio_in_data, cap_tbl[i]);
      wait_frame(base + 2);
      check_bit("slot 0 left valid", rx_tags[1], 1'b1);
      check_bit("slot 0 right valid", rx_tags[0], 1'b1);
      check_sample("slot 3 sample", rx_left[19:12], play_tbl[i]);
      check_sample("slot 4 sample", rx_right[19:12], play_tbl[i]);
      check_bit("slot 3 pad bits", |rx_left[11:0], 1'b0);
      check_bit("slot 4 pad bits", |rx_right[11:0], 1'b0);
    end
  endtask

  task automatic fill_sample_table();
    logic [31:0] r;
    for (int i = 0; i < n_play; i++) begin
      r           = $random(seed);
      play_tbl[i] = r[7:0];
      r           = $random(seed);
      cap_tbl[i]  = r[7:0];
    end
  endtask

  initial begin
    reset          = 1'b1;
    volume         = 5'd8;
    audio_out_data = '0;
    ac97_sdata_in  = 1'b0;
    cap_byte       = '0;
    fill_sample_table();
    run_commands(5'd8);
    run_samples();
    // second pass is a reset in the middle of the run
    run_commands(5'd31);
    if (uut.u_chk.assert_failures == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run("a concurrent assertion in ac97_audio_chk failed");
    end
  end

endmodule

// File: ac97_audio_chk.sv
`timescale 1ns/10ps

module ac97_audio_chk (
  input logic clock_27mhz,
  input logic reset,
  input logic ready,
  input logic audio_reset_b,
  input logic ac97_synch,
  input logic ac97_bit_clock
);

  // failed assertions so far, watched by the testbench
  int assert_failures = 0;

  // ready is a one-cycle strobe
  ready_single_cycle: assert property (
    @(posedge clock_27mhz) disable iff (reset) ready |=> !ready
  ) else begin
    $error("ready high for two cycles in a row");
    assert_failures++;
  end

  // codec only goes back into reset with the system
  reset_b_no_drop: assert property (
    @(posedge clock_27mhz) $fell(audio_reset_b) |-> $past(reset)
  ) else begin
    $error("audio_reset_b fell while reset was low");
    assert_failures++;
  end

  // sync covers the 16 tag bits
  synch_width: assert property (
    @(posedge ac97_bit_clock) disable iff (reset)
      $rose(ac97_synch) |-> ac97_synch [*16] ##1 !ac97_synch
  ) else begin
    $error("ac97_synch high for other than 16 bit clocks");
    assert_failures++;
  end

endmodule

bind ac97_audio_top ac97_audio_chk u_chk (
  .clock_27mhz   (clock_27mhz),
  .reset         (reset),
  .ready         (ready),
  .audio_reset_b (audio_reset_b),
  .ac97_synch    (ac97_synch),
  .ac97_bit_clock(ac97_bit_clock)
);

// File: ac97_audio_top.sv
`timescale 1ns/10ps

module ac97_audio_top import ac97_frame_pkg::*, codec_reg_pkg::*; #(
  parameter int reset_delay_cycles = 1023
) (
  input  logic          clock_27mhz,
  input  logic          reset,
  input  volume_t       volume,
  input  audio_sample_t audio_out_data,
  output audio_sample_t audio_in_data,
  output logic          ready,
  output logic          audio_reset_b,
  output logic          ac97_sdata_out,
  input  logic          ac97_sdata_in,
  output logic          ac97_synch,
  input  logic          ac97_bit_clock
);

  // system domain to link
  codec_addr_t cmd_addr;
  codec_data_t cmd_data;
  logic        cmd_valid;
  pcm_sample_t play_sample;
  // link back to system domain
  logic        frame_ready;
  pcm_sample_t capture_sample;

  // codec reset and register commands
  codec_control #(
    .reset_delay_cycles(reset_delay_cycles)
  ) u_codec_control (
    .clock_27mhz  (clock_27mhz),
    .reset        (reset),
    .ready        (ready),
    .volume       (volume),
    .audio_reset_b(audio_reset_b),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .cmd_valid    (cmd_valid)
  );

  // ready pulse and sample registers
  pcm_sample_path u_pcm_sample_path (
    .clock_27mhz   (clock_27mhz),
    .reset         (reset),
    .frame_ready   (frame_ready),
    .audio_out_data(audio_out_data),
    .capture_sample(capture_sample),
    .ready         (ready),
    .play_sample   (play_sample),
    .audio_in_data (audio_in_data)
  );

  // serial frame on the bit clock
  ac97_link u_ac97_link (
    .ac97_bit_clock(ac97_bit_clock),
    .reset         (reset),
    .cmd_addr      (cmd_addr),
    .cmd_data      (cmd_data),
    .cmd_valid     (cmd_valid),
    .play_sample   (play_sample),
    .frame_ready   (frame_ready),
    .capture_sample(capture_sample),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_synch    (ac97_synch),
    .ac97_sdata_in (ac97_sdata_in)
  );

endmodule

// File: ac97_link.sv
`timescale 1ns/10ps

module ac97_link import ac97_frame_pkg::*, codec_reg_pkg::*; (
  input  logic        ac97_bit_clock,
  input  logic        reset,
  input  codec_addr_t cmd_addr,
  input  codec_data_t cmd_data,
  input  logic        cmd_valid,
  input  pcm_sample_t play_sample,
  output logic        frame_ready,
  output pcm_sample_t capture_sample,
  output logic        ac97_sdata_out,
  output logic        ac97_synch,
  input  logic        ac97_sdata_in
);

  localparam bit_count_t frame_last = bit_count_t'(frame_bits - 1);
  localparam int         slot_msb   = $bits(pcm_sample_t) - 1;

  logic        reset_meta;
  logic        link_reset;
  bit_count_t  bit_count;
  logic        frame_started;
  codec_addr_t l_cmd_addr;
  codec_data_t l_cmd_data;
  logic        l_cmd_v;
  pcm_sample_t l_sample;
  logic        l_play_v;
  pcm_sample_t addr_word;
  pcm_sample_t data_word;
  logic        tx_bit;

  // msb-first pick out of a 20-bit slot
  function automatic logic slot_bit(input pcm_sample_t word, input bit_count_t first,
                                    input bit_count_t pos);
    bit_count_t offset;
    offset = pos - first;
    return word[slot_msb - offset[4:0]];
  endfunction

  // system reset into the bit-clock domain
  always_ff @(posedge ac97_bit_clock) begin
    reset_meta <= reset;
    link_reset <= reset_meta;
  end

  ////////////////////////////////////////////////////////////
  // frame counter, sync, ready window
  ////////////////////////////////////////////////////////////

  // counter parks at 255 in reset so sync rises on the first edge out
  always_ff @(posedge ac97_bit_clock) begin
    if (link_reset) begin
      bit_count      <= frame_last;
      frame_started  <= 1'b0;
      l_cmd_v        <= 1'b0;
      l_play_v       <= 1'b0;
      ac97_synch     <= 1'b0;
      frame_ready    <= 1'b0;
      ac97_sdata_out <= 1'b0;
    end else begin
      bit_count      <= bit_count + 1'b1;
      ac97_sdata_out <= tx_bit;
      // sync leads slot 0 by one bit
      if (bit_count == frame_last) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == sync_last_bit) begin
        ac97_synch <= 1'b0;
      end
      if (bit_count == ready_rise_bit) begin
        frame_ready <= 1'b1;
      end else if (bit_count == ready_fall_bit) begin
        frame_ready <= 1'b0;
      end
      // first frame out of reset goes with every tag but frame-valid clear
      if (bit_count == frame_last) begin
        frame_started <= 1'b1;
        l_cmd_v       <= cmd_valid & frame_started;
        l_play_v      <= frame_started;
      end
    end
  end

  // next frame's payload, system side is long settled by now
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == frame_last) begin
      l_cmd_addr <= cmd_addr;
      l_cmd_data <= cmd_data;
      l_sample   <= play_sample;
    end
  end

  ////////////////////////////////////////////////////////////
  // slot serializer
  ////////////////////////////////////////////////////////////

  assign addr_word = {l_cmd_addr, 12'h000};
  assign data_word = {l_cmd_data, 4'h0};

  always_comb begin
    tx_bit = 1'b0;
    if (bit_count <= slot_tag_last) begin
      // tags, msb first
      case (bit_count[3:0])
        4'd0:       tx_bit = 1'b1;
        4'd1, 4'd2: tx_bit = l_cmd_v;
        4'd3, 4'd4: tx_bit = l_play_v;
        default:    tx_bit = 1'b0;
      endcase
    end else if (bit_count < slot_cmd_data_first) begin
      tx_bit = l_cmd_v & slot_bit(addr_word, slot_cmd_addr_first, bit_count);
    end else if (bit_count < slot_left_first) begin
      tx_bit = l_cmd_v & slot_bit(data_word, slot_cmd_data_first, bit_count);
    end else if (bit_count < slot_right_first) begin
      tx_bit = l_play_v & slot_bit(l_sample, slot_left_first, bit_count);
    end else if (bit_count <= slot_right_last) begin
      // mono, so the right slot repeats the left
      tx_bit = l_play_v & slot_bit(l_sample, slot_right_first, bit_count);
    end
  end

  // codec drives on rising edges, take slot 3 on the falling edge after
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count > slot_left_first && bit_count <= slot_right_first) begin
      capture_sample <= {capture_sample[slot_msb-1:0], ac97_sdata_in};
    end
  end

endmodule

// File: pcm_sample_path.sv
`timescale 1ns/10ps

module pcm_sample_path import ac97_frame_pkg::*; (
  input  logic          clock_27mhz,
  input  logic          reset,
  input  logic          frame_ready,
  input  audio_sample_t audio_out_data,
  input  pcm_sample_t   capture_sample,
  output logic          ready,
  output pcm_sample_t   play_sample,
  output audio_sample_t audio_in_data
);

  // zero fill below the user byte
  localparam int pad_bits = $bits(pcm_sample_t) - audio_bits;

  // [1:0] synchronizer, [2] edge history
  logic [2:0]    frame_ready_sync;
  audio_sample_t play_byte;

  ////////////////////////////////////////////////////////////
  // ready pulse from the bit-clock domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      frame_ready_sync <= '0;
      ready            <= 1'b0;
    end else begin
      frame_ready_sync <= {frame_ready_sync[1:0], frame_ready};
      // rising edge only, one pulse per frame
      ready <= frame_ready_sync[1] & ~frame_ready_sync[2];
    end
  end

  // both directions move on the ready cycle
  // link is between slot 4 and the frame end, so both sides are quiet
  always_ff @(posedge clock_27mhz) begin
    if (ready) begin
      play_byte     <= audio_out_data;
      audio_in_data <= capture_sample[$bits(pcm_sample_t)-1 -: audio_bits];
    end
  end

  // left-justified, same word feeds both slots
  assign play_sample = {play_byte, {pad_bits{1'b0}}};

endmodule

// File: codec_control.sv
`timescale 1ns/10ps

module codec_control import codec_reg_pkg::*; #(
  parameter int reset_delay_cycles = 1023
) (
  input  logic        clock_27mhz,
  input  logic        reset,
  input  logic        ready,
  input  volume_t     volume,
  output logic        audio_reset_b,
  output codec_addr_t cmd_addr,
  output codec_data_t cmd_data,
  output logic        cmd_valid
);

  localparam int delay_bits = $clog2(reset_delay_cycles + 1);

  logic [delay_bits-1:0] delay_count;
  cmd_state_t            state;
  volume_t               atten;

  ////////////////////////////////////////////////////////////
  // codec reset hold-off
  ////////////////////////////////////////////////////////////

  // count up once, then release the codec
  // stays released until the next system reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      delay_count   <= '0;
      audio_reset_b <= 1'b0;
    end else if (delay_count == delay_bits'(reset_delay_cycles)) begin
      audio_reset_b <= 1'b1;
    end else begin
      delay_count <= delay_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // command sequencer
  ////////////////////////////////////////////////////////////

  // codec wants attenuation, not gain
  assign atten = volume_t'(5'd31 - volume);

  // one step per frame, 4-bit state wraps by itself
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state     <= st_read_id0;
      cmd_valid <= 1'b0;
    end else begin
      if (ready) begin
        state <= cmd_state_t'(state + 4'd1);
      end
      // first pass through state 0 opens the command slots
      if (state == st_read_id0) begin
        cmd_valid <= 1'b1;
      end
    end
  end

  // command lags the state by one clock
  always_ff @(posedge clock_27mhz) begin
    case (state)
      st_headphone: begin
        cmd_addr <= reg_headphone_vol;
        cmd_data <= {3'b000, atten, 3'b000, atten};
      end
      st_pcm_vol: begin
        cmd_addr <= reg_pcm_vol;
        cmd_data <= pcm_vol_value;
      end
      st_rec_select: begin
        // same source on both channels
        cmd_addr <= reg_rec_select;
        cmd_data <= {5'b00000, rec_source_mic, 5'b00000, rec_source_mic};
      end
      st_rec_gain: begin
        cmd_addr <= reg_rec_gain;
        cmd_data <= rec_gain_value;
      end
      st_mic_gain: begin
        cmd_addr <= reg_mic_gain;
        cmd_data <= mic_gain_value;
      end
      st_beep: begin
        cmd_addr <= reg_beep_vol;
        cmd_data <= beep_vol_value;
      end
      st_bypass: begin
        cmd_addr <= reg_general;
        cmd_data <= general_value;
      end
      // id reads fill the wait and idle states
      default: begin
        cmd_addr <= reg_read_id;
        cmd_data <= '0;
      end
    endcase
  end

endmodule

// File: codec_reg_pkg.sv
package codec_reg_pkg;

  // register command fields
  typedef logic [7:0]  codec_addr_t;
  typedef logic [15:0] codec_data_t;

  // headphone volume, 31 is loudest
  typedef logic [4:0] volume_t;

  // record mux select
  typedef logic [2:0] rec_source_t;

  ////////////////////////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////////////////////////

  // bit 7 set marks a read
  localparam codec_addr_t reg_read_id       = 8'h80;
  localparam codec_addr_t reg_headphone_vol = 8'h04;
  localparam codec_addr_t reg_pcm_vol       = 8'h18;
  localparam codec_addr_t reg_rec_select    = 8'h1A;
  localparam codec_addr_t reg_rec_gain      = 8'h1C;
  localparam codec_addr_t reg_mic_gain      = 8'h0E;
  localparam codec_addr_t reg_beep_vol      = 8'h0A;
  localparam codec_addr_t reg_general       = 8'h20;

  // fixed values written each pass
  localparam codec_data_t pcm_vol_value  = 16'h0808;
  // record gain at max
  localparam codec_data_t rec_gain_value = 16'h0F0F;
  // +20 dB mic boost
  localparam codec_data_t mic_gain_value = 16'h8048;
  localparam codec_data_t beep_vol_value = 16'h0000;
  // pcm out bypasses 3d mix
  localparam codec_data_t general_value  = 16'h8000;

  // mic input on the record mux
  localparam rec_source_t rec_source_mic = 3'd0;

  // command sequencer, one state per frame
  typedef enum logic [3:0] {
    st_read_id0, st_read_id1, st_wait2, st_headphone,
    st_wait4, st_pcm_vol, st_rec_select, st_rec_gain,
    st_wait8, st_mic_gain, st_beep, st_bypass,
    st_idle12, st_idle13, st_idle14, st_idle15
  } cmd_state_t;

endpackage

// File: ac97_frame_pkg.sv
package ac97_frame_pkg;

  ////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////

  // bit clocks per frame, 13 slots squeezed into 256
  localparam int frame_bits = 256;

  // bit position within the current frame
  typedef logic [7:0] bit_count_t;

  ////////////////////////////////////////////////////////////
  // slot boundaries
  ////////////////////////////////////////////////////////////

  // slot 0, tag bits
  localparam bit_count_t slot_tag_last       = 8'd15;
  // slot 1, command address
  localparam bit_count_t slot_cmd_addr_first = 8'd16;
  // slot 2, command data
  localparam bit_count_t slot_cmd_data_first = 8'd36;
  // slot 3, left pcm
  localparam bit_count_t slot_left_first     = 8'd56;
  // slot 4, right pcm
  localparam bit_count_t slot_right_first    = 8'd76;
  localparam bit_count_t slot_right_last     = 8'd95;

  ////////////////////////////////////////////////////////////
  // marker positions
  ////////////////////////////////////////////////////////////

  // sync drops after the tag slot
  localparam bit_count_t sync_last_bit  = 8'd15;
  // frame_ready window, wraps across the frame boundary
  localparam bit_count_t ready_rise_bit = 8'd128;
  localparam bit_count_t ready_fall_bit = 8'd2;

  ////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////

  // full 20-bit slot word
  typedef logic [19:0] pcm_sample_t;

  // user side byte, sits in the msbs of a slot
  localparam int audio_bits = 8;
  typedef logic [audio_bits-1:0] audio_sample_t;

endpackage
